// File: verilog/loader_pkg.sv
`default_nettype none

package loader_pkg;

    // widths on the file side and the ram side
    typedef logic [7:0]  byte_t;         // one file byte or ram data byte
    typedef logic [15:0] addr_t;         // z80 address space
    typedef logic [8:0]  block_len_t;    // needs 9 bits to count 256
    typedef logic [15:0] file_index_t;   // menu index of the download
    typedef logic [23:0] file_offset_t;  // offset of the byte in the file

    // control fsm
    typedef enum logic [3:0] {
        IDLE,       // waiting for a download or an erase request
        GET_TYPE,
        GET_LEN,
        GET_LSB,
        GET_MSB,
        SETUP,      // branch on the block type
        TRANSFER,   // payload bytes go to ram
        IGNORE,     // skip an unknown block
        EXECUTE,
        FINISH,
        SET_ZERO,
        DO_ZERO     // erase sweep in progress
    } loader_state_t;

    // cmd block type codes
    localparam byte_t BLOCK_EOF   = 8'h00;
    localparam byte_t BLOCK_DATA  = 8'h01;
    localparam byte_t BLOCK_ENTRY = 8'h02;

    // erase memory map
    localparam addr_t ERASE_BASE         = 16'h4000;  // first write lands one above
    localparam addr_t ERASE_LAST         = 16'hffff;
    localparam addr_t ERASE_EXEC_POINT   = 16'hfffd;  // gives the cpu time to see the request
    localparam addr_t CLEAR_ROUTINE_ADDR = 16'hffe1;
    localparam logic [11:0] CLEAR_ROUTINE_PAGE = 12'hffe;

    // screen clear routine written at ffe1 during the sweep
    localparam byte_t CLEAR_ROUTINE [16] = '{
        8'hf3,                // di
        8'h21, 8'h00, 8'h3c,  // ld hl with 3c00h
        8'h11, 8'h01, 8'h3c,  // ld de with 3c01h
        8'h3e, 8'h20,         // ld a with a space
        8'h77,                // store first space
        8'h01, 8'hff, 8'h03,  // ld bc with 03ffh
        8'hed, 8'hb0,         // ldir fills the rest of the screen
        8'hc3                 // jp 0000h using the zeros that follow
    };

endpackage

`default_nettype wire

// File: verilog/block_if.sv
`timescale 1ns/1ps
`default_nettype none

interface block_if import loader_pkg::*; ();

    // capture strobes from the fsm
    logic  capture_type;  // byte is the block type
    logic  capture_len;   // byte is the length
    logic  capture_lsb;   // low byte of load address
    logic  capture_msb;   // high byte of load address
    logic  consume;       // one payload byte taken

    // block state held by the tracker
    byte_t block_type;
    logic  len_zero;      // nothing left in the block
    addr_t block_addr;    // load or entry address

    modport tracker (
        input  capture_type, capture_len, capture_lsb, capture_msb, consume,
        output block_type, len_zero, block_addr
    );

    modport control (
        output capture_type, capture_len, capture_lsb, capture_msb, consume,
        input  block_type, len_zero, block_addr
    );

    modport writer (input block_addr);

endinterface

`default_nettype wire

// File: verilog/ram_write_if.sv
`timescale 1ns/1ps
`default_nettype none

interface ram_write_if ();

    // commands from the fsm
    logic block_start;       // next payload byte starts a new block
    logic payload_write;     // write the current file byte
    logic erase_start;       // load the sweep base address
    logic erase_write;       // advance the sweep by one address

    // sweep status from the writer
    logic erase_exec_point;  // address has reached the execute point
    logic erase_end;         // last address written

    modport control (
        output block_start, payload_write, erase_start, erase_write,
        input  erase_exec_point, erase_end
    );

    modport writer (
        input  block_start, payload_write, erase_start, erase_write,
        output erase_exec_point, erase_end
    );

endinterface

`default_nettype wire

// File: verilog/loader_control.sv
`timescale 1ns/1ps
`default_nettype none

module loader_control import loader_pkg::*; #(
    parameter file_index_t FILE_INDEX = 16'd2   // menu slot of cmd files
) (
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire logic         erase_mem,
    input  wire logic         ioctl_download,
    input  wire logic         ioctl_wr,
    input  wire file_index_t  ioctl_index,
    input  wire file_offset_t ioctl_addr,
    block_if.control          blk,
    ram_write_if.control      wr,
    output logic              loader_download,
    output addr_t             execute_addr,
    output logic              execute_enable
);

    loader_state_t state;
    logic strobe;     // byte strobe while the download is still on
    logic start_ok;   // new cmd download at offset zero
    logic parsing;    // states that give up when the download drops

    assign strobe   = ioctl_wr && ioctl_download;
    assign start_ok = ioctl_download && (ioctl_index == FILE_INDEX) && (ioctl_addr == '0);
    assign parsing  = state inside {GET_TYPE, GET_LEN, GET_LSB, GET_MSB,
                                    SETUP, TRANSFER, IGNORE};

    // strobes to the tracker and the writer
    always_comb begin
        blk.capture_type  = 1'b0;
        blk.capture_len   = 1'b0;
        blk.capture_lsb   = 1'b0;
        blk.capture_msb   = 1'b0;
        blk.consume       = 1'b0;
        wr.block_start    = 1'b0;
        wr.payload_write  = 1'b0;
        wr.erase_start    = 1'b0;
        wr.erase_write    = 1'b0;
        case (state)
            GET_TYPE: blk.capture_type = strobe;
            GET_LEN:  blk.capture_len  = strobe && (blk.block_type != BLOCK_EOF);
            GET_LSB:  blk.capture_lsb  = strobe;
            GET_MSB:  blk.capture_msb  = strobe;
            SETUP:    wr.block_start   = (blk.block_type == BLOCK_DATA);
            TRANSFER: begin
                blk.consume      = strobe && !blk.len_zero;
                wr.payload_write = strobe && !blk.len_zero;  // byte lands one cycle later
            end
            IGNORE:   blk.consume    = strobe && !blk.len_zero;  // count only
            SET_ZERO: wr.erase_start = 1'b1;
            DO_ZERO:  wr.erase_write = !wr.erase_end;  // one address per cycle
            default:  ;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state           <= IDLE;
            loader_download <= 1'b0;
            execute_addr    <= '0;
            execute_enable  <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    execute_enable <= 1'b0;  // request held until back here
                    if (start_ok) begin
                        loader_download <= 1'b1;
                        state           <= GET_TYPE;
                    end else if (erase_mem) begin
                        loader_download <= 1'b1;
                        state           <= SET_ZERO;
                    end
                end
                GET_TYPE: begin
                    if (strobe) begin
                        state <= GET_LEN;  // type is in the tracker next cycle
                    end
                end
                GET_LEN: begin
                    if (blk.block_type == BLOCK_EOF) begin
                        loader_download <= 1'b0;  // end of file
                        state           <= FINISH;
                    end else if (strobe) begin
                        if (blk.block_type == BLOCK_DATA || blk.block_type == BLOCK_ENTRY)
                            state <= GET_LSB;
                        else
                            state <= IGNORE;   // unknown type skipped by length
                    end
                end
                GET_LSB: begin
                    if (strobe) begin
                        state <= GET_MSB;
                    end
                end
                GET_MSB: begin
                    if (strobe) begin
                        state <= SETUP;
                    end
                end
                SETUP: begin
                    if (blk.block_type == BLOCK_DATA) begin
                        state <= TRANSFER;
                    end else if (blk.block_type == BLOCK_ENTRY) begin
                        state <= EXECUTE;
                    end else begin
                        loader_download <= 1'b0;  // not reachable in a sane file
                        state           <= FINISH;
                    end
                end
                TRANSFER, IGNORE: begin
                    if (blk.len_zero) begin
                        state <= GET_TYPE;  // next block header
                    end
                end
                EXECUTE: begin
                    execute_addr    <= blk.block_addr;
                    execute_enable  <= 1'b1;
                    loader_download <= 1'b0;
                    state           <= FINISH;
                end
                FINISH: begin
                    loader_download <= 1'b0;
                    state           <= IDLE;
                end
                SET_ZERO: state <= DO_ZERO;  // writer loads the base now
                DO_ZERO: begin
                    if (wr.erase_exec_point) begin
                        execute_addr   <= CLEAR_ROUTINE_ADDR;  // reboot through the clear routine
                        execute_enable <= 1'b1;
                    end
                    if (wr.erase_end && !erase_mem) begin
                        state <= FINISH;  // wait for the end of the erase pulse
                    end
                end
                default: state <= IDLE;
            endcase

            // download dropped mid file
            if (parsing && !ioctl_download) begin
                loader_download <= 1'b0;
                state           <= IDLE;
            end
        end
    end

    // ram commands only inside an active load
    assert property (@(posedge clock) disable iff (reset)
        (wr.payload_write || wr.erase_write) |-> loader_download)
        else $error("ram write command outside a load");

endmodule

`default_nettype wire

// File: verilog/block_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module block_tracker import loader_pkg::*; (
    input  wire logic  clock,
    input  wire logic  reset,
    input  wire byte_t ioctl_dout,   // header and payload bytes
    block_if.tracker   blk
);

    block_len_t len_q;    // payload bytes still to come
    block_len_t len_dec;  // length byte decoded for the current type

    // cmd length coding
    always_comb begin
        case (blk.block_type)
            BLOCK_DATA: begin
                // length counts the two address bytes too
                case (ioctl_dout)
                    8'd0:    len_dec = 9'd254;
                    8'd1:    len_dec = 9'd255;
                    8'd2:    len_dec = 9'd256;
                    default: len_dec = {1'b0, ioctl_dout} - 9'd2;
                endcase
            end
            BLOCK_ENTRY: len_dec = '0;  // address only and no payload
            default:     len_dec = {1'b0, ioctl_dout};  // bytes to skip
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            blk.block_type <= BLOCK_EOF;
            len_q          <= '0;
        end else begin
            if (blk.capture_type) begin
                blk.block_type <= ioctl_dout;
            end
            if (blk.capture_len) begin
                len_q <= len_dec;
            end else if (blk.consume) begin
                len_q <= len_q - 9'd1;  // one byte taken
            end
        end
    end

    // load address bytes arrive lsb first
    always_ff @(posedge clock) begin
        if (blk.capture_lsb) begin
            blk.block_addr[7:0] <= ioctl_dout;
        end
        if (blk.capture_msb) begin
            blk.block_addr[15:8] <= ioctl_dout;
        end
    end

    assign blk.len_zero = (len_q == '0);

    // a cmd block carries at most 256 payload bytes and the count never wraps
    assert property (@(posedge clock) disable iff (reset)
        len_q <= 9'd256)
        else $error("block length above 256");

endmodule

`default_nettype wire

// File: verilog/ram_writer.sv
`timescale 1ns/1ps
`default_nettype none

module ram_writer import loader_pkg::*; (
    input  wire logic   clock,
    input  wire logic   reset,
    input  wire byte_t  ioctl_dout,   // payload byte of the current strobe
    block_if.writer     blk,
    ram_write_if.writer wr,
    output logic        loader_wr,
    output addr_t       loader_addr,
    output byte_t       loader_data
);

    logic  first_byte;  // next payload byte goes to block_addr
    byte_t erase_byte;  // data for the next sweep address

    // clear routine sits in the ffe page and the rest is zero
    always_comb begin
        if (loader_addr[15:4] == CLEAR_ROUTINE_PAGE)
            erase_byte = CLEAR_ROUTINE[loader_addr[3:0]];  // indexed by the previous address
        else
            erase_byte = '0;
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            loader_wr   <= 1'b0;
            loader_addr <= '0;
            loader_data <= '0;
            first_byte  <= 1'b0;
        end else begin
            loader_wr <= 1'b0;  // single cycle write pulse
            if (wr.block_start) begin
                first_byte <= 1'b1;
            end else if (wr.payload_write) begin
                loader_addr <= first_byte ? blk.block_addr : loader_addr + 16'd1;
                loader_data <= ioctl_dout;
                loader_wr   <= 1'b1;
                first_byte  <= 1'b0;
            end else if (wr.erase_start) begin
                loader_addr <= ERASE_BASE;  // no write at the base itself
            end else if (wr.erase_write) begin
                loader_addr <= loader_addr + 16'd1;
                loader_data <= erase_byte;
                loader_wr   <= 1'b1;
            end
        end
    end

    // sweep status straight from the address register
    assign wr.erase_exec_point = (loader_addr == ERASE_EXEC_POINT);
    assign wr.erase_end        = (loader_addr == ERASE_LAST);  // writer stops here

    // sweep must never wrap into the rom area
    assert property (@(posedge clock) disable iff (reset)
        wr.erase_write |=> loader_addr > ERASE_BASE)
        else $error("erase address below sweep base");

endmodule

`default_nettype wire

// File: verilog/cmd_loader_top.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_loader_top import loader_pkg::*; #(
    parameter file_index_t FILE_INDEX = 16'd2   // menu index of cmd files
) (
    input  wire logic         clock,
    input  wire logic         reset,
    input  wire logic         erase_mem,        // pulse to wipe ram
    input  wire logic         ioctl_download,   // high for the whole file
    input  wire logic         ioctl_wr,
    input  wire file_index_t  ioctl_index,
    input  wire byte_t        ioctl_dout,
    input  wire file_offset_t ioctl_addr,
    output logic              loader_wr,
    output logic              loader_download,
    output addr_t             loader_addr,
    output byte_t             loader_data,
    output addr_t             execute_addr,
    output logic              execute_enable
);

    block_if     blk_bus ();  // header capture and block status
    ram_write_if wr_bus ();   // write commands and sweep status

    loader_control #(
        .FILE_INDEX (FILE_INDEX)
    ) i_loader_control (
        .clock           (clock),
        .reset           (reset),
        .erase_mem       (erase_mem),
        .ioctl_download  (ioctl_download),
        .ioctl_wr        (ioctl_wr),
        .ioctl_index     (ioctl_index),
        .ioctl_addr      (ioctl_addr),
        .blk             (blk_bus.control),
        .wr              (wr_bus.control),
        .loader_download (loader_download),
        .execute_addr    (execute_addr),
        .execute_enable  (execute_enable)
    );

    // file bytes go to both the tracker and the writer
    block_tracker i_block_tracker (
        .clock      (clock),
        .reset      (reset),
        .ioctl_dout (ioctl_dout),
        .blk        (blk_bus.tracker)
    );

    ram_writer i_ram_writer (
        .clock       (clock),
        .reset       (reset),
        .ioctl_dout  (ioctl_dout),
        .blk         (blk_bus.writer),
        .wr          (wr_bus.writer),
        .loader_wr   (loader_wr),
        .loader_addr (loader_addr),
        .loader_data (loader_data)
    );

endmodule

`default_nettype wire

// File: testbench/tb_cmd_loader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cmd_loader import loader_pkg::*; ();

    logic         clock;
    logic         reset;
    logic         erase_mem;
    logic         ioctl_download;
    logic         ioctl_wr;
    file_index_t  ioctl_index;
    byte_t        ioctl_dout;
    file_offset_t ioctl_addr;
    logic         loader_wr;
    logic         loader_download;
    addr_t        loader_addr;
    byte_t        loader_data;
    addr_t        execute_addr;
    logic         execute_enable;

    // test table, one entry per stim record
    string  names[$];
    string  kinds[$];
    logic   exp_en[$];
    addr_t  exp_addr[$];
    int     drops[$];
    int     firsts[$];   // index of the first file byte
    int     counts[$];
    byte_t  file_bytes[$];

    byte_t  ram [addr_t];      // ram model of the current test
    byte_t  exp_mem [addr_t];
    string  cur_name;
    int     errors;
    int     checks;
    integer seed;
    logic   exec_seen;
    logic   exec_seen_dl;      // request seen with the download still up
    addr_t  exec_seen_addr;
    logic   dl_seen;

    cmd_loader_top #(
        .FILE_INDEX (16'd2)
    ) i_cmd_loader_top (
        .clock           (clock),
        .reset           (reset),
        .erase_mem       (erase_mem),
        .ioctl_download  (ioctl_download),
        .ioctl_wr        (ioctl_wr),
        .ioctl_index     (ioctl_index),
        .ioctl_dout      (ioctl_dout),
        .ioctl_addr      (ioctl_addr),
        .loader_wr       (loader_wr),
        .loader_download (loader_download),
        .loader_addr     (loader_addr),
        .loader_data     (loader_data),
        .execute_addr    (execute_addr),
        .execute_enable  (execute_enable)
    );

    always #2 clock = ~clock;  // 4 ns period

    // ram and status monitor
    always @(posedge clock) begin
        if (loader_wr) begin
            if (ram.exists(loader_addr)) begin
                $display("%s: address %h written a second time", cur_name, loader_addr);
                errors++;
            end
            ram[loader_addr] = loader_data;
        end
        if (execute_enable) begin
            exec_seen      = 1'b1;
            exec_seen_addr = execute_addr;
            if (loader_download)
                exec_seen_dl = 1'b1;
        end
        if (loader_download)
            dl_seen = 1'b1;
    end

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("Mismatch %s %s: expected %h, actual %h", cur_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic read_stim();
        int    fd;
        int    r;
        int    n;
        int    i;
        int    drop;
        string tok;
        string kind;
        string line;
        logic  en;
        addr_t ea;
        byte_t b;
        fd = $fopen("testbench/cmd_loader_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/cmd_loader_stim.txt");
            errors++;
            return;
        end
        while ($fscanf(fd, "%s", tok) == 1) begin
            if (tok.substr(0, 0) == "#") begin
                r = $fgets(line, fd);  // comment line
                continue;
            end
            r = $fscanf(fd, "%s %h %h %d %d", kind, en, ea, drop, n);
            if (r != 5) begin
                $display("stim record %s is incomplete", tok);
                errors++;
                break;
            end
            names.push_back(tok);
            kinds.push_back(kind);
            exp_en.push_back(en);
            exp_addr.push_back(ea);
            drops.push_back(drop);
            counts.push_back(n);
            firsts.push_back(file_bytes.size());
            for (i = 0; i < n; i++) begin
                r = $fscanf(fd, "%h", b);
                file_bytes.push_back(b);
            end
        end
        $fclose(fd);
    endtask

    // one write pulse, spaced 4 to 6 cycles from the next
    task automatic send_byte(input byte_t b, input int offset);
        int gap;
        gap = 4 + {$random(seed)} % 3;
        @(posedge clock);
        ioctl_wr   <= 1'b1;
        ioctl_dout <= b;
        ioctl_addr <= offset;
        @(posedge clock);
        ioctl_wr <= 1'b0;
        repeat (gap - 2) @(posedge clock);
    endtask

    task automatic wait_download_low(input int limit);
        int n;
        n = 0;
        @(posedge clock);
        while (loader_download && n < limit) begin
            @(posedge clock);
            n++;
        end
        if (loader_download) begin
            $display("%s: loader_download still high after %0d cycles", cur_name, limit);
            errors++;
        end
    endtask

    // cmd decode of the bytes that were sent
    task automatic build_expected(input int first, input int count);
        int    p;
        int    n;
        int    i;
        byte_t kind;
        byte_t len;
        addr_t a;
        exp_mem.delete();
        p = 0;
        while (p < count) begin
            kind = file_bytes[first + p];
            p++;
            if (kind == 8'h00 || p >= count)
                break;  // end of file
            len = file_bytes[first + p];
            p++;
            if (kind == 8'h01)
                n = (len < 3) ? len + 254 : len - 2;  // length includes the address
            else if (kind == 8'h02)
                n = 0;
            else
                n = len;
            if (kind == 8'h01 || kind == 8'h02) begin
                if (p + 2 > count)
                    break;
                a = {file_bytes[first + p + 1], file_bytes[first + p]};
                p += 2;
                if (kind == 8'h02)
                    break;  // entry point ends the load
                for (i = 0; i < n && p < count; i++) begin
                    exp_mem[addr_t'(a + i)] = file_bytes[first + p];
                    p++;
                end
            end else begin
                p += n;  // unknown block skipped
            end
        end
    endtask

    task automatic compare_memory();
        foreach (exp_mem[a]) begin
            if (!ram.exists(a)) begin
                $display("%s: no write at %h", cur_name, a);
                errors++;
            end else begin
                check_equal($sformatf("data at %h", a), exp_mem[a], ram[a]);
            end
        end
        foreach (ram[a]) begin
            if (!exp_mem.exists(a)) begin
                $display("%s: unexpected write at %h", cur_name, a);
                errors++;
            end
        end
    endtask

    task automatic check_erase_memory();
        int    a;
        byte_t e;
        check_equal("erase write count", ERASE_LAST - ERASE_BASE, ram.num());
        for (a = ERASE_BASE + 1; a <= ERASE_LAST; a++) begin
            if (a >= CLEAR_ROUTINE_ADDR && a < CLEAR_ROUTINE_ADDR + 16)
                e = CLEAR_ROUTINE[a - CLEAR_ROUTINE_ADDR];
            else
                e = 8'h00;
            if (!ram.exists(addr_t'(a))) begin
                $display("%s: no write at %h", cur_name, a);
                errors++;
            end else if (ram[addr_t'(a)] !== e) begin
                $display("Mismatch %s data at %h: expected %h, actual %h",
                         cur_name, a, e, ram[addr_t'(a)]);
                errors++;
            end
        end
    endtask

    task automatic run_download(input int t);
        int n;
        int i;
        n = (drops[t] != 0) ? drops[t] : counts[t];
        @(posedge clock);
        ioctl_index    <= (kinds[t] == "wrongindex") ? 16'd3 : 16'd2;
        ioctl_addr     <= '0;
        ioctl_download <= 1'b1;
        repeat (2) @(posedge clock);
        for (i = 0; i < n; i++)
            send_byte(file_bytes[firsts[t] + i], i);
        if (drops[t] != 0) begin
            @(posedge clock);
            ioctl_download <= 1'b0;  // abort in mid payload
            repeat (3) @(posedge clock);
            ioctl_download <= 1'b1;  // sender carries on without a restart at offset zero
            for (i = n; i < counts[t]; i++)
                send_byte(file_bytes[firsts[t] + i], i);
        end
        wait_download_low(100);
        repeat (4) @(posedge clock);
        ioctl_download <= 1'b0;
        ioctl_addr     <= '0;
    endtask

    task automatic run_test(input int t);
        cur_name     = names[t];
        exec_seen    = 1'b0;
        exec_seen_dl = 1'b0;
        dl_seen      = 1'b0;
        ram.delete();
        if (kinds[t] == "erase") begin
            @(posedge clock);
            erase_mem <= 1'b1;
            @(posedge clock);
            erase_mem <= 1'b0;
            wait_download_low(60000);
            repeat (4) @(posedge clock);
            check_erase_memory();
            check_equal("execute before download fall", exp_en[t], exec_seen_dl);
            check_equal("execute_addr", exp_addr[t], exec_seen_addr);
        end else begin
            run_download(t);
            if (kinds[t] == "wrongindex")
                exp_mem.delete();
            else
                build_expected(firsts[t], (drops[t] != 0) ? drops[t] : counts[t]);
            compare_memory();
            check_equal("loader_download raised", kinds[t] != "wrongindex", dl_seen);
            check_equal("execute_enable", exp_en[t], exec_seen);
            if (exp_en[t])
                check_equal("execute_addr", exp_addr[t], exec_seen_addr);
        end
        repeat (4) @(posedge clock);
    endtask

    initial begin
        int t;
        int limit;
        clock          = 1'b0;
        reset          = 1'b1;
        erase_mem      = 1'b0;
        ioctl_download = 1'b0;
        ioctl_wr       = 1'b0;
        ioctl_index    = '0;
        ioctl_dout     = '0;
        ioctl_addr     = '0;
        errors         = 0;
        checks         = 0;
        seed           = 33117;
        read_stim();
        limit = 60000 + 10 * file_bytes.size();  // erase sweep dominates
        fork
            begin
                repeat (limit) @(posedge clock);
                $display("watchdog expired after %0d cycles", limit);
                $display("TEST FAILED");
                $finish;
            end
        join_none
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        repeat (3) @(posedge clock);
        for (t = 0; t < names.size(); t++)
            run_test(t);
        $display("tests %0d, checks %0d, errors %0d", names.size(), checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
verilog/loader_pkg.sv
verilog/block_if.sv
verilog/ram_write_if.sv
verilog/loader_control.sv
verilog/block_tracker.sv
verilog/ram_writer.sv
verilog/cmd_loader_top.sv
testbench/tb_cmd_loader.sv

// File: testbench/cmd_loader_stim.txt
# name kind exec_en exec_addr drop count, then count file bytes in hex
# drop is the number of bytes sent before the download falls, 0 sends them all
data_blocks cmd 0 0000 0 268
01 05 00 50 11 22 33 01 02 80 60
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10 11 12 13 14 15 16 17 18 19 1a 1b 1c 1d 1e 1f
20 21 22 23 24 25 26 27 28 29 2a 2b 2c 2d 2e 2f 30 31 32 33 34 35 36 37 38 39 3a 3b 3c 3d 3e 3f
40 41 42 43 44 45 46 47 48 49 4a 4b 4c 4d 4e 4f 50 51 52 53 54 55 56 57 58 59 5a 5b 5c 5d 5e 5f
60 61 62 63 64 65 66 67 68 69 6a 6b 6c 6d 6e 6f 70 71 72 73 74 75 76 77 78 79 7a 7b 7c 7d 7e 7f
80 81 82 83 84 85 86 87 88 89 8a 8b 8c 8d 8e 8f 90 91 92 93 94 95 96 97 98 99 9a 9b 9c 9d 9e 9f
a0 a1 a2 a3 a4 a5 a6 a7 a8 a9 aa ab ac ad ae af b0 b1 b2 b3 b4 b5 b6 b7 b8 b9 ba bb bc bd be bf
c0 c1 c2 c3 c4 c5 c6 c7 c8 c9 ca cb cc cd ce cf d0 d1 d2 d3 d4 d5 d6 d7 d8 d9 da db dc dd de df
e0 e1 e2 e3 e4 e5 e6 e7 e8 e9 ea eb ec ed ee ef f0 f1 f2 f3 f4 f5 f6 f7 f8 f9 fa fb fc fd fe ff
00
skip_block cmd 0 0000 0 20
01 05 00 70 a1 a2 a3 05 04 de ad be ef 01 04 10 70 b1 b2 00
entry_block cmd 1 5200 0 12
01 03 00 52 c9 02 02 00 52 55 66 77
aborted cmd 0 0000 7 12
01 0a 00 80 01 02 03 04 05 06 07 08
after_abort cmd 0 0000 0 9
01 06 00 81 d1 d2 d3 d4 00
erase erase 1 ffe1 0 0
wrong_index wrongindex 0 0000 0 8
01 05 00 90 e1 e2 e3 00
